// File: net_cfg_pkg.sv
package net_cfg_pkg;

    localparam logic [47:0] SRC_MAC    = 48'h00_0a_35_01_fe_c0;
    localparam logic [47:0] DST_MAC    = 48'h02_00_c0_a8_16_64;  // locally administered peer
    localparam logic [31:0] SRC_IP     = 32'hc0_a8_16_c8;        // 192.168.22.200
    localparam logic [31:0] DST_IP     = 32'hc0_a8_16_64;        // 192.168.22.100
    localparam logic [15:0] SRC_PORT   = 16'd8080;
    localparam logic [15:0] DST_PORT   = 16'd8080;
    localparam logic [7:0]  IP_TTL     = 8'h80;

    localparam logic [15:0] PKG_LEN    = 16'd1400;  // max udp payload per datagram
    localparam logic [7:0]  IFG_CYCLES = 8'd12;     // idle cycles after frame end

    // transfer sequencing states of the segmenter
    localparam logic [1:0]  SEG_IDLE     = 2'd0;
    localparam logic [1:0]  SEG_SPLIT    = 2'd1;
    localparam logic [1:0]  SEG_WAIT_END = 2'd2;
    localparam logic [1:0]  SEG_GAP      = 2'd3;

endpackage

// File: frame_pkg.sv
package frame_pkg;

    localparam logic [15:0] PREAMBLE_BYTES = 16'd8;
    localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hd5;

    localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
    localparam logic [15:0] ETH_HDR_BYTES  = 16'd14;
    localparam logic [15:0] IP_HDR_BYTES   = 16'd20;
    localparam logic [15:0] UDP_HDR_BYTES  = 16'd8;
    localparam logic [15:0] HDR_BYTES      = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;
    localparam logic [15:0] PAYLOAD_OFFS   = PREAMBLE_BYTES + HDR_BYTES;  // first payload byte
    localparam logic [15:0] MIN_PAYLOAD    = 16'd18;  // pads frame to 64 bytes with fcs
    localparam logic [15:0] FCS_BYTES      = 16'd4;

    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_TOS         = 8'h00;
    localparam logic [15:0] IP_FLAGS_FRAG  = 16'h4000;  // don't fragment
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    localparam logic [31:0] CRC_POLY_REFL  = 32'hedb8_8320;
    localparam logic [31:0] CRC_INIT       = 32'hffff_ffff;

endpackage

// File: udp_tx_segmenter.sv
`timescale 1ns/1ps

module udp_tx_segmenter
    import net_cfg_pkg::*;
(
    input  logic        gmii_tx_clk,
    input  logic        rst_n,
    input  logic        tx_send_i,
    input  logic [15:0] tx_len_i,
    input  logic [15:0] tx_addr_i,
    input  logic        frame_end_i,
    output logic        pkt_start_o,
    output logic [15:0] pkt_len_o,
    output logic [15:0] pkt_addr_o,
    output logic        tx_done_o
);

    logic [2:0]  send_sync;
    logic        send_rise;
    logic [1:0]  state;
    logic [15:0] remain;
    logic [15:0] next_addr;
    logic [15:0] chunk;
    logic [7:0]  gap_cnt;
    logic        gap_done;
    logic        issue;

    assign send_rise = send_sync[1] & ~send_sync[2];  // edge after two sync flops
    assign chunk     = (remain > PKG_LEN) ? PKG_LEN : remain;
    assign gap_done  = (state == SEG_GAP) && (gap_cnt == IFG_CYCLES - 8'd1);
    // next datagram goes out straight from the end of the gap
    assign issue     = (remain != 16'd0) && ((state == SEG_SPLIT) || gap_done);

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            send_sync   <= 3'b000;
            state       <= SEG_IDLE;
            remain      <= 16'd0;
            next_addr   <= 16'd0;
            gap_cnt     <= 8'd0;
            pkt_start_o <= 1'b0;
            pkt_len_o   <= 16'd0;
            pkt_addr_o  <= 16'd0;
            tx_done_o   <= 1'b0;
        end
        else
        begin
            send_sync   <= {send_sync[1:0], tx_send_i};
            pkt_start_o <= 1'b0;
            if (issue)
            begin
                pkt_start_o <= 1'b1;
                pkt_len_o   <= chunk;
                pkt_addr_o  <= next_addr;
                remain      <= remain - chunk;
                next_addr   <= next_addr + chunk;
                state       <= SEG_WAIT_END;
            end
            else
            begin
                case (state)
                    SEG_IDLE:
                    begin
                        if (send_rise)  // strobes only count here
                        begin
                            remain    <= tx_len_i;
                            next_addr <= tx_addr_i;
                            tx_done_o <= 1'b0;
                            state     <= SEG_SPLIT;
                        end
                    end
                    SEG_SPLIT:
                    begin
                        tx_done_o <= 1'b1;  // zero length request
                        state     <= SEG_IDLE;
                    end
                    SEG_WAIT_END:
                    begin
                        if (frame_end_i)
                        begin
                            gap_cnt <= 8'd0;
                            state   <= SEG_GAP;
                        end
                    end
                    default:
                    begin
                        if (gap_done)
                        begin
                            tx_done_o <= 1'b1;  // nothing left
                            state     <= SEG_IDLE;
                        end
                        else
                        begin
                            gap_cnt <= gap_cnt + 8'd1;
                        end
                    end
                endcase
            end
        end
    end

    a_pkt_len: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        pkt_start_o |-> (pkt_len_o != 16'd0) && (pkt_len_o <= PKG_LEN));

endmodule

// File: ip_udp_hdr_gen.sv
`timescale 1ns/1ps

module ip_udp_hdr_gen
    import net_cfg_pkg::*;
    import frame_pkg::*;
(
    input  logic        gmii_tx_clk,
    input  logic        rst_n,
    input  logic        pkt_start_i,
    input  logic [15:0] pkt_len_i,
    input  logic [15:0] pkt_addr_i,
    output logic        hdr_valid_o,
    output logic [15:0] ip_total_len_o,
    output logic [15:0] udp_len_o,
    output logic [15:0] ip_id_o,
    output logic [15:0] ip_csum_o,
    output logic [15:0] payload_len_o,
    output logic [15:0] payload_addr_o
);

    logic [15:0] tot_len;
    logic [15:0] id_cnt;
    logic [19:0] sum;
    logic [16:0] fold1;
    logic [15:0] fold2;

    assign tot_len = pkt_len_i + IP_HDR_BYTES + UDP_HDR_BYTES;

    // ten header words, checksum word counted as zero
    assign sum = 20'({IP_VER_IHL, IP_TOS}) + 20'(tot_len) + 20'(id_cnt)
               + 20'(IP_FLAGS_FRAG) + 20'({IP_TTL, IP_PROTO_UDP})
               + 20'(SRC_IP[31:16]) + 20'(SRC_IP[15:0])
               + 20'(DST_IP[31:16]) + 20'(DST_IP[15:0]);
    assign fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);  // second carry fold

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hdr_valid_o <= 1'b0;
            id_cnt      <= 16'd0;
        end
        else
        begin
            hdr_valid_o <= pkt_start_i;
            if (pkt_start_i)
            begin
                id_cnt <= id_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge gmii_tx_clk)
    begin
        if (pkt_start_i)
        begin
            ip_total_len_o <= tot_len;
            udp_len_o      <= pkt_len_i + UDP_HDR_BYTES;
            ip_id_o        <= id_cnt;
            ip_csum_o      <= ~fold2;
            payload_len_o  <= pkt_len_i;
            payload_addr_o <= pkt_addr_i;
        end
    end

endmodule

// File: frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer
    import net_cfg_pkg::*;
    import frame_pkg::*;
(
    input  logic        gmii_tx_clk,
    input  logic        rst_n,
    input  logic        hdr_valid_i,
    input  logic [15:0] ip_total_len_i,
    input  logic [15:0] udp_len_i,
    input  logic [15:0] ip_id_i,
    input  logic [15:0] ip_csum_i,
    input  logic [15:0] payload_len_i,
    input  logic [15:0] payload_addr_i,
    input  logic [7:0]  ram_data_i,
    output logic [15:0] ram_addr_o,
    output logic        byte_valid_o,
    output logic [7:0]  byte_data_o,
    output logic        crc_en_o,
    output logic        byte_last_o
);

    logic                   active;
    logic [15:0]            cnt;
    logic                   emit;
    logic [15:0]            idx;
    logic [15:0]            cur_len;
    logic [15:0]            last_idx;
    logic [15:0]            pay_idx;
    logic [8:0]             bit_pos;
    logic [7:0]             next_byte;
    logic [15:0]            tot_q;
    logic [15:0]            udp_q;
    logic [15:0]            id_q;
    logic [15:0]            csum_q;
    logic [15:0]            len_q;
    logic [15:0]            addr_q;
    logic [HDR_BYTES*8-1:0] hdr_vec;

    assign emit     = hdr_valid_i | active;
    assign idx      = hdr_valid_i ? 16'd0 : cnt;  // byte 0 goes out right after hdr_valid
    assign cur_len  = hdr_valid_i ? payload_len_i : len_q;
    assign last_idx = PAYLOAD_OFFS - 16'd1 + ((cur_len < MIN_PAYLOAD) ? MIN_PAYLOAD : cur_len);
    assign pay_idx  = idx - PAYLOAD_OFFS;
    assign bit_pos  = 9'((PAYLOAD_OFFS - 16'd1 - idx) << 3);

    // eth, ip, udp headers, first byte on top
    assign hdr_vec = {DST_MAC, SRC_MAC, ETH_TYPE_IPV4,
                      IP_VER_IHL, IP_TOS, tot_q, id_q, IP_FLAGS_FRAG,
                      IP_TTL, IP_PROTO_UDP, csum_q, SRC_IP, DST_IP,
                      SRC_PORT, DST_PORT, udp_q, 16'h0000};

    always_comb
    begin
        if (idx < PREAMBLE_BYTES - 16'd1)
            next_byte = PREAMBLE_BYTE;
        else if (idx == PREAMBLE_BYTES - 16'd1)
            next_byte = SFD_BYTE;
        else if (idx < PAYLOAD_OFFS)
            next_byte = hdr_vec[bit_pos +: 8];
        else if (pay_idx < len_q)
            next_byte = ram_data_i;
        else
            next_byte = 8'h00;  // pad
    end

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active       <= 1'b0;
            cnt          <= 16'd0;
            ram_addr_o   <= 16'd0;
            byte_valid_o <= 1'b0;
            crc_en_o     <= 1'b0;
            byte_last_o  <= 1'b0;
        end
        else if (emit)
        begin
            byte_valid_o <= 1'b1;
            crc_en_o     <= (idx >= PREAMBLE_BYTES);
            byte_last_o  <= (idx == last_idx);
            active       <= (idx != last_idx);
            cnt          <= idx + 16'd1;
            // two bytes early to cover the ram read latency
            if (idx >= PAYLOAD_OFFS - 16'd2)
                ram_addr_o <= addr_q + idx - (PAYLOAD_OFFS - 16'd2);
        end
        else
        begin
            byte_valid_o <= 1'b0;
            crc_en_o     <= 1'b0;
            byte_last_o  <= 1'b0;
        end
    end

    always_ff @(posedge gmii_tx_clk)
    begin
        if (emit)
            byte_data_o <= next_byte;
        if (hdr_valid_i)
        begin
            tot_q  <= ip_total_len_i;
            udp_q  <= udp_len_i;
            id_q   <= ip_id_i;
            csum_q <= ip_csum_i;
            len_q  <= payload_len_i;
            addr_q <= payload_addr_i;
        end
    end

    a_no_hole: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        byte_valid_o && !byte_last_o |=> byte_valid_o);

endmodule

// File: fcs_append.sv
`timescale 1ns/1ps

module fcs_append
    import frame_pkg::*;
(
    input  logic       gmii_tx_clk,
    input  logic       rst_n,
    input  logic       byte_valid_i,
    input  logic [7:0] byte_data_i,
    input  logic       crc_en_i,
    input  logic       byte_last_i,
    output logic       gmii_tx_en_o,
    output logic [7:0] gmii_txd_o,
    output logic       frame_end_o
);

    logic [31:0] crc;
    logic        fcs_active;
    logic [1:0]  fcs_cnt;

    function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] d);
        logic [31:0] c;
        c = c_in ^ {24'h000000, d};
        for (int i = 0; i < 8; i++)
        begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY_REFL) : (c >> 1);  // lsb first
        end
        return c;
    endfunction

    always_ff @(posedge gmii_tx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            crc          <= CRC_INIT;
            fcs_active   <= 1'b0;
            fcs_cnt      <= 2'd0;
            gmii_tx_en_o <= 1'b0;
            gmii_txd_o   <= 8'h00;
            frame_end_o  <= 1'b0;
        end
        else
        begin
            frame_end_o <= 1'b0;
            if (fcs_active)
            begin
                gmii_tx_en_o <= 1'b1;
                gmii_txd_o   <= ~crc[7:0];
                crc          <= {8'h00, crc[31:8]};  // next fcs byte down
                fcs_cnt      <= fcs_cnt + 2'd1;
                if (fcs_cnt == 2'(FCS_BYTES - 16'd1))
                begin
                    fcs_active  <= 1'b0;
                    frame_end_o <= 1'b1;
                end
            end
            else
            begin
                gmii_tx_en_o <= byte_valid_i;
                gmii_txd_o   <= byte_data_i;
                if (crc_en_i)
                    crc <= crc_byte(crc, byte_data_i);
                else
                    crc <= CRC_INIT;  // preamble and idle
                if (byte_last_i)
                begin
                    fcs_active <= 1'b1;
                    fcs_cnt    <= 2'd0;
                end
            end
        end
    end

    a_end_of_burst: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
        frame_end_o |-> gmii_tx_en_o ##1 !gmii_tx_en_o);

endmodule

// File: udp_tx_top.sv
`timescale 1ns/1ps

module udp_tx_top
(
    input  logic        gmii_tx_clk,
    input  logic        rst_n,
    input  logic        tx_send_i,
    input  logic [15:0] tx_len_i,
    input  logic [15:0] tx_addr_i,
    input  logic [7:0]  ram_data_i,
    output logic [15:0] ram_addr_o,
    output logic        tx_done_o,
    output logic        gmii_tx_en_o,
    output logic [7:0]  gmii_txd_o
);

    logic        pkt_start;
    logic [15:0] pkt_len;
    logic [15:0] pkt_addr;
    logic        frame_end;
    logic        hdr_valid;
    logic [15:0] ip_total_len;
    logic [15:0] udp_len;
    logic [15:0] ip_id;
    logic [15:0] ip_csum;
    logic [15:0] payload_len;
    logic [15:0] payload_addr;
    logic        byte_valid;
    logic [7:0]  byte_data;
    logic        crc_en;
    logic        byte_last;

    udp_tx_segmenter i_segmenter (
        .gmii_tx_clk (gmii_tx_clk),
        .rst_n       (rst_n),
        .tx_send_i   (tx_send_i),
        .tx_len_i    (tx_len_i),
        .tx_addr_i   (tx_addr_i),
        .frame_end_i (frame_end),
        .pkt_start_o (pkt_start),
        .pkt_len_o   (pkt_len),
        .pkt_addr_o  (pkt_addr),
        .tx_done_o   (tx_done_o)
    );

    ip_udp_hdr_gen i_hdr_gen (
        .gmii_tx_clk    (gmii_tx_clk),
        .rst_n          (rst_n),
        .pkt_start_i    (pkt_start),
        .pkt_len_i      (pkt_len),
        .pkt_addr_i     (pkt_addr),
        .hdr_valid_o    (hdr_valid),
        .ip_total_len_o (ip_total_len),
        .udp_len_o      (udp_len),
        .ip_id_o        (ip_id),
        .ip_csum_o      (ip_csum),
        .payload_len_o  (payload_len),
        .payload_addr_o (payload_addr)
    );

    frame_serializer i_serializer (
        .gmii_tx_clk    (gmii_tx_clk),
        .rst_n          (rst_n),
        .hdr_valid_i    (hdr_valid),
        .ip_total_len_i (ip_total_len),
        .udp_len_i      (udp_len),
        .ip_id_i        (ip_id),
        .ip_csum_i      (ip_csum),
        .payload_len_i  (payload_len),
        .payload_addr_i (payload_addr),
        .ram_data_i     (ram_data_i),
        .ram_addr_o     (ram_addr_o),
        .byte_valid_o   (byte_valid),
        .byte_data_o    (byte_data),
        .crc_en_o       (crc_en),
        .byte_last_o    (byte_last)
    );

    fcs_append i_fcs (
        .gmii_tx_clk  (gmii_tx_clk),
        .rst_n        (rst_n),
        .byte_valid_i (byte_valid),
        .byte_data_i  (byte_data),
        .crc_en_i     (crc_en),
        .byte_last_i  (byte_last),
        .gmii_tx_en_o (gmii_tx_en_o),
        .gmii_txd_o   (gmii_txd_o),
        .frame_end_o  (frame_end)
    );

endmodule

// File: tb_udp_tx.sv
`timescale 1ns/1ps

module tb_udp_tx
    import net_cfg_pkg::*;
    import frame_pkg::*;
;

    typedef logic [7:0] byte_q_t [$];

    logic        gmii_tx_clk;
    logic        rst_n;
    logic        tx_send_i;
    logic [15:0] tx_len_i;
    logic [15:0] tx_addr_i;
    logic [7:0]  ram_data_i;
    logic [15:0] ram_addr_o;
    logic        tx_done_o;
    logic        gmii_tx_en_o;
    logic [7:0]  gmii_txd_o;

    logic [7:0]  mem [0:65535];
    logic [15:0] rd_addr;
    int          exp_len [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_id [$];
    logic [15:0] next_id = 16'd0;
    int          fail_count = 0;
    int          frames_checked = 0;
    int          budget_cycles = 0;
    byte_q_t     burst;
    bit          in_frame = 1'b0;
    int          idle_cnt = 0;
    int          rnd_len [10];
    logic [15:0] rnd_addr [10];

    udp_tx_top i_udp_tx_top (
        .gmii_tx_clk  (gmii_tx_clk),
        .rst_n        (rst_n),
        .tx_send_i    (tx_send_i),
        .tx_len_i     (tx_len_i),
        .tx_addr_i    (tx_addr_i),
        .ram_data_i   (ram_data_i),
        .ram_addr_o   (ram_addr_o),
        .tx_done_o    (tx_done_o),
        .gmii_tx_en_o (gmii_tx_en_o),
        .gmii_txd_o   (gmii_txd_o)
    );

    always #50 gmii_tx_clk = ~gmii_tx_clk;

    // sync read ram with one cycle latency
    always @(posedge gmii_tx_clk)
    begin
        rd_addr = ram_addr_o;
        #1;
        ram_data_i = mem[rd_addr];
    end

    task automatic fail_now(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            fail_now($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    function automatic byte_q_t build_frame(input int len, input logic [15:0] addr,
                                            input logic [15:0] id);
        byte_q_t                f;
        logic [HDR_BYTES*8-1:0] hdr;
        logic [31:0]            sum;
        logic [31:0]            crc;
        logic [15:0]            tot;
        logic [15:0]            csum;
        int                     i;
        int                     b;
        tot = 16'(len) + 16'd28;
        sum = 32'({IP_VER_IHL, IP_TOS}) + 32'(tot) + 32'(id) + 32'(IP_FLAGS_FRAG)
            + 32'({IP_TTL, IP_PROTO_UDP}) + 32'(SRC_IP[31:16]) + 32'(SRC_IP[15:0])
            + 32'(DST_IP[31:16]) + 32'(DST_IP[15:0]);
        while (sum[31:16] != 16'd0)
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);  // end-around carry
        csum = ~sum[15:0];
        hdr = {DST_MAC, SRC_MAC, ETH_TYPE_IPV4, IP_VER_IHL, IP_TOS, tot, id, IP_FLAGS_FRAG,
               IP_TTL, IP_PROTO_UDP, csum, SRC_IP, DST_IP, SRC_PORT, DST_PORT,
               16'(len) + 16'd8, 16'h0000};
        for (i = 0; i < 7; i++)
            f.push_back(8'h55);
        f.push_back(8'hd5);
        for (i = 0; i < 42; i++)
            f.push_back(hdr[8*(41-i) +: 8]);
        for (i = 0; i < len; i++)
            f.push_back(mem[16'(addr + 16'(i))]);
        while (f.size() < 8 + 42 + 18)
            f.push_back(8'h00);  // pad to 64 byte frame
        crc = 32'hffff_ffff;
        for (i = 8; i < f.size(); i++)
        begin
            crc = crc ^ {24'h000000, f[i]};
            for (b = 0; b < 8; b++)
                crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
        end
        crc = ~crc;
        for (i = 0; i < 4; i++)
            f.push_back(crc[8*i +: 8]);  // lsb first
        return f;
    endfunction

    function automatic int transfer_cycles(input int len);
        int remain;
        int chunk;
        int cyc;
        cyc = 30;
        remain = len;
        while (remain > 0)
        begin
            chunk = (remain > int'(PKG_LEN)) ? int'(PKG_LEN) : remain;
            cyc += 54 + ((chunk < 18) ? 18 : chunk) + int'(IFG_CYCLES) + 10;
            remain -= chunk;
        end
        return cyc;
    endfunction

    task automatic compare_frame();
        byte_q_t     expect_frame;
        int          len;
        logic [15:0] addr;
        logic [15:0] id;
        int          i;
        if (exp_len.size() == 0)
            fail_now("a frame appeared on the GMII output while no datagram was expected");
        len = exp_len.pop_front();
        addr = exp_addr.pop_front();
        id = exp_id.pop_front();
        expect_frame = build_frame(len, addr, id);
        check_value("frame length", 32'(burst.size()), 32'(expect_frame.size()));
        for (i = 0; i < expect_frame.size(); i++)
            check_value($sformatf("gmii_txd_o[%0d]", i), 32'(burst[i]), 32'(expect_frame[i]));
        frames_checked++;
        burst.delete();
    endtask

    // sample at the falling edge once outputs settle
    always @(negedge gmii_tx_clk)
    begin
        if (rst_n)
        begin
            if (gmii_tx_en_o)
            begin
                if (!in_frame && frames_checked > 0 && idle_cnt < int'(IFG_CYCLES))
                    fail_now($sformatf("gap of only %0d idle cycles between frames", idle_cnt));
                in_frame = 1'b1;
                burst.push_back(gmii_txd_o);
            end
            else if (in_frame)
            begin
                in_frame = 1'b0;
                idle_cnt = 1;
                compare_frame();
            end
            else
            begin
                idle_cnt++;
            end
        end
    end

    task automatic run_transfer(input int len, input logic [15:0] addr, input bit busy_strobe);
        int          remain;
        int          chunk;
        logic [15:0] a;
        int          n;
        remain = len;
        a = addr;
        while (remain > 0)
        begin
            chunk = (remain > int'(PKG_LEN)) ? int'(PKG_LEN) : remain;
            exp_len.push_back(chunk);
            exp_addr.push_back(a);
            exp_id.push_back(next_id);
            next_id++;
            a = a + 16'(chunk);
            remain -= chunk;
        end
        @(posedge gmii_tx_clk);
        #1;
        tx_len_i = 16'(len);
        tx_addr_i = addr;
        tx_send_i = 1'b1;
        repeat (2) @(posedge gmii_tx_clk);
        #1;
        tx_send_i = 1'b0;
        n = 0;
        while (tx_done_o && n < 8)
        begin
            @(posedge gmii_tx_clk);
            #1;
            n++;
        end
        check_value("tx_done_o", 32'(tx_done_o), 32'd0);
        if (busy_strobe)
        begin
            repeat (300) @(posedge gmii_tx_clk);
            #1;
            tx_len_i = 16'd100;  // must be ignored
            tx_send_i = 1'b1;
            repeat (2) @(posedge gmii_tx_clk);
            #1;
            tx_send_i = 1'b0;
        end
        do
        begin
            @(posedge gmii_tx_clk);
            #1;
        end
        while (!tx_done_o);
        check_value("pending datagrams", 32'(exp_len.size()), 32'd0);
    endtask

    initial
    begin
        int i;
        int budget;
        gmii_tx_clk = 1'b0;
        rst_n = 1'b0;
        tx_send_i = 1'b0;
        tx_len_i = 16'd0;
        tx_addr_i = 16'd0;
        ram_data_i = 8'h00;
        void'($urandom(32'hf030_75ac));
        for (i = 0; i < 65536; i++)
            mem[i] = 8'($urandom);
        for (i = 0; i < 10; i++)
        begin
            rnd_len[i] = int'($urandom % 4000) + 1;
            rnd_addr[i] = 16'($urandom);
        end
        budget = transfer_cycles(10) + transfer_cycles(3000) + transfer_cycles(2000) + 10;
        for (i = 0; i < 10; i++)
            budget += transfer_cycles(rnd_len[i]);
        budget_cycles = 2 * budget + 1000;

        repeat (3)
        begin
            @(posedge gmii_tx_clk);
            #1;
            check_value("gmii_tx_en_o", 32'(gmii_tx_en_o), 32'd0);
            check_value("tx_done_o", 32'(tx_done_o), 32'd0);
        end
        rst_n = 1'b1;
        repeat (2)
        begin
            @(posedge gmii_tx_clk);
            #1;
            check_value("gmii_tx_en_o", 32'(gmii_tx_en_o), 32'd0);
            check_value("tx_done_o", 32'(tx_done_o), 32'd0);
        end

        run_transfer(10, 16'h0100, 1'b0);      // single padded frame
        run_transfer(3000, 16'hff00, 1'b0);    // three datagrams with address wrap
        run_transfer(2000, 16'h8000, 1'b1);    // strobe while busy
        for (i = 0; i < 10; i++)
            run_transfer(rnd_len[i], rnd_addr[i], 1'b0);

        repeat (20) @(posedge gmii_tx_clk);
        if (fail_count == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("TESTBENCH FAILED");
            $fatal(1, "checks failed");
        end
    end

    initial
    begin
        wait (budget_cycles != 0);
        repeat (budget_cycles) @(posedge gmii_tx_clk);
        $display("timeout: the run did not finish within %0d clock cycles", budget_cycles);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: filelist.f
net_cfg_pkg.sv
frame_pkg.sv
udp_tx_segmenter.sv
ip_udp_hdr_gen.sv
frame_serializer.sv
fcs_append.sv
udp_tx_top.sv
tb_udp_tx.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_udp_tx \
    -f filelist.f -o tb_udp_tx > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_udp_tx > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1
